/* common/dmem_params.svh */
// Width settings for the data-memory subsystem.
// Include wherever an address or data width is needed.

`ifndef DMEM_PARAMS_SVH
`define DMEM_PARAMS_SVH

// ======================================================================
// address widths
// ======================================================================

// byte address seen at the top level, 12 bits gives 4 KiB
`define DMEM_ADDR_W 12

// word address into the SRAM, low two byte-offset bits dropped
`define DMEM_WORD_ADDR_W (`DMEM_ADDR_W - 2)

// ======================================================================
// data width
// ======================================================================

`define DMEM_DATA_W 32

`endif

/* common/dmem_pkg.sv */
// Shared types for the data-memory subsystem.
// Referenced by scoped name from the aligner, the SRAM bus and the top.

`default_nettype none

`include "dmem_params.svh"

package dmem_pkg;

	// ======================================================================
	// memory opcodes
	// ======================================================================

	// loads first, then stores
	// bit 2 set with low bits >= 01 marks a store
	typedef enum logic [2:0] {
		LB  = 3'd0,
		LH  = 3'd1,
		LW  = 3'd2,
		LBU = 3'd3,
		LHU = 3'd4,
		SB  = 3'd5,
		SH  = 3'd6,
		SW  = 3'd7
	} mem_op_e;

	// ======================================================================
	// data types
	// ======================================================================

	// one memory word
	typedef logic [`DMEM_DATA_W-1:0] word_t;

	// one write-enable bit per byte lane
	typedef logic [`DMEM_DATA_W/8-1:0] strb_t;

endpackage

`default_nettype wire

/* common/sram_if.sv */
// Bus between the load/store aligner and the single-port SRAM.
// The aligner takes the ctrl side, the SRAM the mem side.

`default_nettype none

`include "dmem_params.svh"

interface sram_if;

	// access enable, one per request
	logic                         en;
	// byte-lane write strobes, all clear for a read
	dmem_pkg::strb_t              we;
	// word address
	logic [`DMEM_WORD_ADDR_W-1:0] addr;
	// write word, already steered into lanes
	dmem_pkg::word_t              wdata;
	// read word, valid the cycle after en
	dmem_pkg::word_t              rdata;

	// requester side
	modport ctrl (output en, output we, output addr, output wdata, input rdata);

	// memory side
	modport mem (input en, input we, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

/* sram/sp_sram.sv */
// Single-port byte-writable SRAM model for the data memory.
// Writes land at the clock edge, reads come back one cycle later.
// Reset clears the whole array.

`default_nettype none

`include "dmem_params.svh"

module sp_sram (
	input  logic clk,
	input  logic rst,
	sram_if.mem  bus
);

	localparam int BYTE_W = 8;
	localparam int LANES  = `DMEM_DATA_W / BYTE_W;
	localparam int DEPTH  = 1 << `DMEM_WORD_ADDR_W;

	// storage array
	dmem_pkg::word_t              mem [DEPTH];

	// registered read address and enable
	logic [`DMEM_WORD_ADDR_W-1:0] addr_q;
	logic                         en_q;

	// ======================================================================
	// address and enable capture
	// ======================================================================

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			en_q   <= 1'b0;
			addr_q <= '0;
		end
		else
		begin
			en_q   <= bus.en;
			addr_q <= bus.addr;
		end
	end

	// ======================================================================
	// byte-lane write
	// ======================================================================

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			// wipe every word
			for (int w = 0; w < DEPTH; w++)
				mem[w] <= '0;
		end
		else if (bus.en)
		begin
			// only lanes with a strobe bit
			for (int b = 0; b < LANES; b++)
			begin
				if (bus.we[b])
					mem[bus.addr][b*BYTE_W +: BYTE_W] <= bus.wdata[b*BYTE_W +: BYTE_W];
			end
		end
	end

	// read port, zero after an idle cycle
	assign bus.rdata = en_q ? mem[addr_q] : '0;

endmodule

`default_nettype wire

/* src/lsu_align.sv */
// Load/store aligner in front of the data SRAM.
// Requests go straight to the SRAM bus, load results come back one
// cycle later, lane-selected and extended.

`default_nettype none

`include "dmem_params.svh"

module lsu_align (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    req,
	input  dmem_pkg::mem_op_e       op,
	input  logic [`DMEM_ADDR_W-1:0] addr,
	input  dmem_pkg::word_t         wdata,
	output dmem_pkg::word_t         rdata,
	output logic                    rdata_valid,
	output logic                    misaligned,
	sram_if.ctrl                    mem
);

	// access size, 0 byte, 1 halfword, 2 word
	logic [1:0]      size_c;
	logic            is_load_c;
	logic            is_signed_c;
	logic            mis_c;
	logic            acc_c;
	dmem_pkg::strb_t strb_base;
	dmem_pkg::word_t wdata_steer;

	// response stage
	logic            load_q;
	logic            mis_q;
	logic            signed_q;
	logic [1:0]      size_q;
	logic [1:0]      off_q;
	dmem_pkg::word_t lane_word;

	// ======================================================================
	// opcode decode
	// ======================================================================

	always_comb
	begin
		size_c      = 2'd2;
		is_load_c   = 1'b1;
		is_signed_c = 1'b0;
		case (op)
			dmem_pkg::LB:  begin size_c = 2'd0; is_signed_c = 1'b1; end
			dmem_pkg::LH:  begin size_c = 2'd1; is_signed_c = 1'b1; end
			dmem_pkg::LW:  size_c = 2'd2;
			dmem_pkg::LBU: size_c = 2'd0;
			dmem_pkg::LHU: size_c = 2'd1;
			dmem_pkg::SB:  begin size_c = 2'd0; is_load_c = 1'b0; end
			dmem_pkg::SH:  begin size_c = 2'd1; is_load_c = 1'b0; end
			dmem_pkg::SW:  begin size_c = 2'd2; is_load_c = 1'b0; end
			default:       size_c = 2'd2;
		endcase
	end

	// halfword needs bit 0 clear, word needs both low bits clear
	assign mis_c = ((size_c == 2'd1) && addr[0]) ||
	               ((size_c == 2'd2) && (addr[1:0] != 2'b00));

	// aligned request reaches the SRAM
	assign acc_c = req && !mis_c;

	// ======================================================================
	// store lane steering
	// ======================================================================

	always_comb
	begin
		case (size_c)
			2'd0:    strb_base = 4'b0001;
			2'd1:    strb_base = 4'b0011;
			default: strb_base = 4'b1111;
		endcase
	end

	// replicate into every lane, strobes pick the right ones
	always_comb
	begin
		case (size_c)
			2'd0:    wdata_steer = {4{wdata[7:0]}};
			2'd1:    wdata_steer = {2{wdata[15:0]}};
			default: wdata_steer = wdata;
		endcase
	end

	assign mem.en    = acc_c;
	assign mem.addr  = addr[`DMEM_ADDR_W-1:2];
	assign mem.wdata = wdata_steer;
	// loads keep all strobes low
	assign mem.we    = (acc_c && !is_load_c) ? dmem_pkg::strb_t'(strb_base << addr[1:0]) : '0;

	// ======================================================================
	// response stage
	// ======================================================================

	// control flags
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			load_q <= 1'b0;
			mis_q  <= 1'b0;
		end
		else
		begin
			load_q <= acc_c && is_load_c;
			mis_q  <= req && mis_c;
		end
	end

	// load shape, only looked at when load_q is set
	always_ff @(posedge clk)
	begin
		signed_q <= is_signed_c;
		size_q   <= size_c;
		off_q    <= addr[1:0];
	end

	// addressed lanes moved down to bit 0
	assign lane_word = mem.rdata >> {off_q, 3'b000};

	// sign or zero extension
	always_comb
	begin
		case (size_q)
			2'd0:
				rdata = {{(`DMEM_DATA_W-8){signed_q && lane_word[7]}}, lane_word[7:0]};
			2'd1:
				rdata = {{(`DMEM_DATA_W-16){signed_q && lane_word[15]}}, lane_word[15:0]};
			default:
				rdata = lane_word;
		endcase
	end

	assign rdata_valid = load_q;
	assign misaligned  = mis_q;

endmodule

`default_nettype wire

/* src/dmem_top.sv */
// Data-memory subsystem top.
// Aligner and SRAM joined by the internal SRAM bus, plain ports outside.

`default_nettype none

`include "dmem_params.svh"

module dmem_top (
	input  logic                    clk,
	input  logic                    rst,
	// request, one per cycle
	input  logic                    req,
	input  dmem_pkg::mem_op_e       op,
	input  logic [`DMEM_ADDR_W-1:0] addr,
	input  dmem_pkg::word_t         wdata,
	// load result and error pulse
	output dmem_pkg::word_t         rdata,
	output logic                    rdata_valid,
	output logic                    misaligned
);

	// ======================================================================
	// aligner to SRAM bus
	// ======================================================================

	sram_if sram_bus ();

	// request steering and load extension
	lsu_align u_align (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.op          (op),
		.addr        (addr),
		.wdata       (wdata),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.misaligned  (misaligned),
		.mem         (sram_bus.ctrl)
	);

	// backing store
	sp_sram u_sram (
		.clk (clk),
		.rst (rst),
		.bus (sram_bus.mem)
	);

endmodule

`default_nettype wire

/* tests/dmem_properties.sv */
// Concurrent checks on the aligner's request and response timing.
// Bound into lsu_align; a failing property raises $error.

`default_nettype none

`include "dmem_params.svh"

module dmem_properties (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    req,
	input  dmem_pkg::mem_op_e       op,
	input  logic [`DMEM_ADDR_W-1:0] addr,
	input  logic                    en,
	input  dmem_pkg::strb_t         we,
	input  logic                    rdata_valid,
	input  logic                    misaligned
);
	timeunit 1ns;
	timeprecision 1ps;

	logic is_store;
	logic mis_req;
	logic load_req;

	assign is_store = (op == dmem_pkg::SB) || (op == dmem_pkg::SH) || (op == dmem_pkg::SW);
	// halfword wants an even address, word wants both low bits clear
	assign mis_req  = req && (((op == dmem_pkg::LH || op == dmem_pkg::LHU || op == dmem_pkg::SH)
	                  && addr[0]) || ((op == dmem_pkg::LW || op == dmem_pkg::SW)
	                  && (addr[1:0] != 2'b00)));
	assign load_req = req && !is_store && !mis_req;

	a_no_en_misaligned: assert property (@(posedge clk) disable iff (rst) mis_req |-> !en)
		else $error("SRAM enable raised for a misaligned request");
	a_valid_after_load: assert property (@(posedge clk) disable iff (rst) load_req |=> rdata_valid)
		else $error("rdata_valid missing one cycle after a load");
	a_no_stray_valid: assert property (@(posedge clk) disable iff (rst) !load_req |=> !rdata_valid)
		else $error("rdata_valid without a load one cycle before");
	a_valid_mis_apart: assert property (@(posedge clk) disable iff (rst)
		mis_req |=> (misaligned && !rdata_valid))
		else $error("misaligned missing or rdata_valid set after a misaligned request");
	a_store_strobe: assert property (@(posedge clk) disable iff (rst) (en && is_store) |-> (we != '0))
		else $error("enabled store with no write strobe");

endmodule

// ======================================================================
// attach to every aligner
// ======================================================================

bind lsu_align dmem_properties u_props (
	.clk         (clk),
	.rst         (rst),
	.req         (req),
	.op          (op),
	.addr        (addr),
	.en          (mem.en),
	.we          (mem.we),
	.rdata_valid (rdata_valid),
	.misaligned  (misaligned)
);

`default_nettype wire

/* tests/dmem_tb.sv */
// Directed testbench for the data-memory subsystem.
// Drives dmem_top and checks loads against a byte-array reference model.

`default_nettype none

`include "dmem_params.svh"

module dmem_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int AW           = `DMEM_ADDR_W;
	localparam int RESP_TIMEOUT = 16;

	logic              clk;
	logic              rst;
	logic              req;
	dmem_pkg::mem_op_e op;
	logic [AW-1:0]     addr;
	dmem_pkg::word_t   wdata;
	dmem_pkg::word_t   rdata;
	logic              rdata_valid;
	logic              misaligned;

	// reference memory, one entry per byte address
	logic [7:0]        ref_mem [1 << AW];
	logic [31:0]       lfsr_state    = 32'hbf4f03bc;
	int                err_count     = 0;
	int                timeout_count = 0;

	dmem_top u_dut (
		.clk         (clk),
		.rst         (rst),
		.req         (req),
		.op          (op),
		.addr        (addr),
		.wdata       (wdata),
		.rdata       (rdata),
		.rdata_valid (rdata_valid),
		.misaligned  (misaligned)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ======================================================================
	// stimulus source and reference model
	// ======================================================================

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// little-endian lanes, signed ops copy the top bit of the last byte
	function automatic dmem_pkg::word_t expect_load(input dmem_pkg::mem_op_e lop,
			input logic [AW-1:0] a);
		int i;
		i = int'(a);
		case (lop)
			dmem_pkg::LB:  return {{24{ref_mem[i][7]}}, ref_mem[i]};
			dmem_pkg::LBU: return {24'h0, ref_mem[i]};
			dmem_pkg::LH:  return {{16{ref_mem[i+1][7]}}, ref_mem[i+1], ref_mem[i]};
			dmem_pkg::LHU: return {16'h0, ref_mem[i+1], ref_mem[i]};
			default:       return {ref_mem[i+3], ref_mem[i+2], ref_mem[i+1], ref_mem[i]};
		endcase
	endfunction

	function automatic void model_store(input dmem_pkg::mem_op_e sop, input logic [AW-1:0] a,
			input dmem_pkg::word_t d);
		int n;
		n = (sop == dmem_pkg::SB) ? 1 : (sop == dmem_pkg::SH) ? 2 : 4;
		for (int k = 0; k < n; k++)
			ref_mem[int'(a) + k] = d[8*k +: 8];
	endfunction

	// ======================================================================
	// compare tasks
	// ======================================================================

	task automatic check_word(input dmem_pkg::word_t got, input dmem_pkg::word_t exp,
			input string msg);
		if (got !== exp)
		begin
			$display("FAIL %0t ns: %s, got 0x%08h expected 0x%08h", $time, msg, got, exp);
			err_count++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string msg);
		if (got !== exp)
		begin
			$display("FAIL %0t ns: %s, got %b expected %b", $time, msg, got, exp);
			err_count++;
		end
	endtask

	// one request, then its response one cycle after the edge
	task automatic access(input dmem_pkg::mem_op_e aop, input logic [AW-1:0] a,
			input dmem_pkg::word_t d, input logic bad);
		dmem_pkg::word_t exp;
		logic            is_ld;
		int              cycles;
		string           tag;
		is_ld = !(aop inside {dmem_pkg::SB, dmem_pkg::SH, dmem_pkg::SW});
		tag   = $sformatf("%s at 0x%03h", aop.name(), a);
		exp   = '0;
		if (is_ld && !bad)
			exp = expect_load(aop, a);
		else if (!bad)
			model_store(aop, a, d);
		op    = aop;
		addr  = a;
		wdata = d;
		req   = 1'b1;
		@(posedge clk);
		#1;
		req    = 1'b0;
		cycles = 0;
		// good stores have no pulse to wait for
		while ((is_ld || bad) && !rdata_valid && !misaligned && cycles < RESP_TIMEOUT)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (cycles == RESP_TIMEOUT)
		begin
			$display("timeout: no response to %s within %0d cycles", tag, RESP_TIMEOUT);
			timeout_count++;
		end
		else if (cycles != 0)
		begin
			$display("FAIL %0t ns: %s answered %0d cycles late", $time, tag, cycles);
			err_count++;
		end
		check_flag(rdata_valid, is_ld && !bad, {"rdata_valid, ", tag});
		check_flag(misaligned, bad, {"misaligned, ", tag});
		if (is_ld && !bad)
			check_word(rdata, exp, tag);
	endtask

	// ======================================================================
	// directed tests
	// ======================================================================

	task automatic reset_reads_zero();
		logic [31:0] r;
		for (int k = 0; k < 8; k++)
		begin
			r = rand_bits(AW - 2);
			access(dmem_pkg::LW, {r[AW-3:0], 2'b00}, '0, 1'b0);
		end
	endtask

	task automatic word_roundtrip();
		logic [31:0] r;
		for (int k = 0; k < 8; k++)
		begin
			r = rand_bits(AW - 2);
			access(dmem_pkg::SW, {r[AW-3:0], 2'b00}, rand_bits(32), 1'b0);
			access(dmem_pkg::LW, {r[AW-3:0], 2'b00}, '0, 1'b0);
		end
	endtask

	task automatic sub_word_stores();
		logic [31:0]   r;
		logic [AW-1:0] base;
		r    = rand_bits(AW - 2);
		base = {r[AW-3:0], 2'b00};
		access(dmem_pkg::SW, base, 32'h5a5a_a5a5, 1'b0);
		for (int k = 0; k < 4; k++)
		begin
			access(dmem_pkg::SB, base + AW'(k), rand_bits(32), 1'b0);
			access(dmem_pkg::LW, base, '0, 1'b0);
		end
		for (int k = 0; k < 4; k += 2)
		begin
			access(dmem_pkg::SH, base + AW'(k), rand_bits(32), 1'b0);
			access(dmem_pkg::LW, base, '0, 1'b0);
		end
	endtask

	// top bit of each byte forced set, then forced clear
	task automatic load_extension();
		logic [31:0]     r;
		logic [AW-1:0]   base;
		dmem_pkg::word_t d;
		for (int p = 0; p < 2; p++)
		begin
			r    = rand_bits(AW - 2);
			base = {r[AW-3:0], 2'b00};
			d    = rand_bits(32);
			d    = (p == 0) ? (d | 32'h8080_8080) : (d & 32'h7f7f_7f7f);
			access(dmem_pkg::SW, base, d, 1'b0);
			for (int k = 0; k < 4; k++)
			begin
				access(dmem_pkg::LB, base + AW'(k), '0, 1'b0);
				access(dmem_pkg::LBU, base + AW'(k), '0, 1'b0);
			end
			for (int k = 0; k < 4; k += 2)
			begin
				access(dmem_pkg::LH, base + AW'(k), '0, 1'b0);
				access(dmem_pkg::LHU, base + AW'(k), '0, 1'b0);
			end
		end
	endtask

	task automatic misaligned_access();
		logic [31:0]   r;
		logic [AW-1:0] base;
		r    = rand_bits(AW - 2);
		base = {r[AW-3:0], 2'b00};
		access(dmem_pkg::SW, base, rand_bits(32), 1'b0);
		for (int k = 1; k < 4; k++)
		begin
			access(dmem_pkg::LW, base + AW'(k), '0, 1'b1);
			access(dmem_pkg::SW, base + AW'(k), rand_bits(32), 1'b1);
		end
		for (int k = 1; k < 4; k += 2)
		begin
			access(dmem_pkg::LH, base + AW'(k), '0, 1'b1);
			access(dmem_pkg::SH, base + AW'(k), rand_bits(32), 1'b1);
		end
		// word must be untouched
		access(dmem_pkg::LW, base, '0, 1'b0);
	endtask

	// one request per cycle over eight words near 0x100
	task automatic back_to_back_burst();
		logic [31:0]       r;
		logic [AW-1:0]     a;
		dmem_pkg::mem_op_e bop;
		dmem_pkg::word_t   d;
		dmem_pkg::word_t   exp;
		logic              pend;
		pend = 1'b0;
		exp  = '0;
		// idle cycle so the last load pulse before the burst is gone
		@(posedge clk);
		#1;
		for (int n = 0; n <= 64; n++)
		begin
			// previous request answers while the next is presented
			check_flag(rdata_valid, pend, $sformatf("rdata_valid, burst step %0d", n));
			check_flag(misaligned, 1'b0, $sformatf("misaligned, burst step %0d", n));
			if (pend)
				check_word(rdata, exp, $sformatf("burst load before step %0d", n));
			if (n == 64)
				break;
			r   = rand_bits(3);
			bop = dmem_pkg::mem_op_e'(r[2:0]);
			r   = rand_bits(5);
			a   = AW'(32'h100 + {27'h0, r[4:2], 2'b00});
			if (bop inside {dmem_pkg::LB, dmem_pkg::LBU, dmem_pkg::SB})
				a[1:0] = r[1:0];
			else if (bop inside {dmem_pkg::LH, dmem_pkg::LHU, dmem_pkg::SH})
				a[1:0] = {r[0], 1'b0};
			d    = rand_bits(32);
			pend = !(bop inside {dmem_pkg::SB, dmem_pkg::SH, dmem_pkg::SW});
			if (pend)
				exp = expect_load(bop, a);
			else
				model_store(bop, a, d);
			op    = bop;
			addr  = a;
			wdata = d;
			req   = 1'b1;
			@(posedge clk);
			#1;
		end
		req = 1'b0;
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================

	initial
	begin
		rst   = 1'b1;
		req   = 1'b0;
		op    = dmem_pkg::LW;
		addr  = '0;
		wdata = '0;
		for (int i = 0; i < (1 << AW); i++)
			ref_mem[i] = 8'h00;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_reads_zero();
		word_roundtrip();
		sub_word_stores();
		load_extension();
		misaligned_access();
		back_to_back_burst();
		@(posedge clk);
		#1;
		$display("errors %0d, timeouts %0d", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/dmem_pkg.sv
common/sram_if.sv
sram/sp_sram.sv
src/lsu_align.sv
src/dmem_top.sv
tests/dmem_properties.sv
tests/dmem_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module dmem_tb -o dmem_sim || exit 1
out=$(./obj_dir/dmem_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx '=== PASS ===' && echo "simulation passed" || { echo "simulation failed"; exit 1; }
